/* common/decodePkg.sv */
package decodePkg;

    ////////////////////////////////////////////////////////////////////////////
    // instruction format widths and field positions
    ////////////////////////////////////////////////////////////////////////////

    localparam int INSTR_W    = 32;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;
    localparam int REG_ADDR_W = 5;

    localparam int OPCODE_LSB = 26;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;

    typedef logic [INSTR_W-1:0]    instrT;
    typedef logic [OPCODE_W-1:0]   opcodeT;
    typedef logic [FUNCT_W-1:0]    functT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;

    ////////////////////////////////////////////////////////////////////////////
    // datapath encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        ALU_SLL  = 4'b0000,
        ALU_SRA  = 4'b0001,
        ALU_SRL  = 4'b0010,
        ALU_ADD  = 4'b0101,
        ALU_SUB  = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_OR   = 4'b1000,
        ALU_NOR  = 4'b1010,
        ALU_SLT  = 4'b1011,
        ALU_SLTU = 4'b1100,
        ALU_PASS = 4'b1101    // also the idle op
    } aluOpT;

    typedef enum logic [1:0] {
        EXT_SIGN  = 2'b00,
        EXT_ZERO  = 2'b01,
        EXT_SHAMT = 2'b10     // shift amount into operand B
    } extOpT;

    ////////////////////////////////////////////////////////////////////////////
    // primary opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam opcodeT OP_SPECIAL = 6'b000000;    // selects the function table
    localparam opcodeT OP_J       = 6'b000010;
    localparam opcodeT OP_JAL     = 6'b000011;
    localparam opcodeT OP_BEQ     = 6'b000100;
    localparam opcodeT OP_BNE     = 6'b000101;
    localparam opcodeT OP_BLEZ    = 6'b000110;
    localparam opcodeT OP_ADDI    = 6'b001000;
    localparam opcodeT OP_ADDIU   = 6'b001001;
    localparam opcodeT OP_SLTI    = 6'b001010;
    localparam opcodeT OP_ANDI    = 6'b001100;
    localparam opcodeT OP_ORI     = 6'b001101;
    localparam opcodeT OP_LUI     = 6'b001111;
    localparam opcodeT OP_LB      = 6'b100000;
    localparam opcodeT OP_LW      = 6'b100011;
    localparam opcodeT OP_SW      = 6'b101011;

    ////////////////////////////////////////////////////////////////////////////
    // function codes under OP_SPECIAL
    ////////////////////////////////////////////////////////////////////////////

    localparam functT FN_SLL     = 6'b000000;
    localparam functT FN_SRL     = 6'b000010;
    localparam functT FN_SRA     = 6'b000011;
    localparam functT FN_SLLV    = 6'b000100;
    localparam functT FN_JR      = 6'b001000;
    localparam functT FN_SYSCALL = 6'b001100;
    localparam functT FN_ADD     = 6'b100000;
    localparam functT FN_ADDU    = 6'b100001;
    localparam functT FN_SUB     = 6'b100010;
    localparam functT FN_AND     = 6'b100100;
    localparam functT FN_OR      = 6'b100101;
    localparam functT FN_NOR     = 6'b100111;
    localparam functT FN_SLT     = 6'b101010;
    localparam functT FN_SLTU    = 6'b101011;

    localparam regAddrT LINK_REG = 5'd31;    // return address for jal

endpackage

/* decoder/specialDecode.sv */
`timescale 1ns/10ps

module specialDecode (
    input  decodePkg::functT funct,
    output decodePkg::aluOpT aluOp,
    output decodePkg::extOpT extOp,
    output logic             aluSrc,
    output logic             regDst,
    output logic             regWrite,
    output logic             memWrite,
    output logic             memToReg,
    output logic             loadByte,
    output logic             lui,
    output logic             jr,
    output logic             jal,
    output logic             j,
    output logic             beq,
    output logic             bne,
    output logic             blez,
    output logic             syscall,
    output logic             known
);

    always_comb begin
        aluOp    = decodePkg::ALU_PASS;
        extOp    = decodePkg::EXT_SIGN;
        aluSrc   = 1'b0;
        regDst   = 1'b0;
        regWrite = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        loadByte = 1'b0;
        lui      = 1'b0;
        jr       = 1'b0;
        jal      = 1'b0;
        j        = 1'b0;
        beq      = 1'b0;
        bne      = 1'b0;
        blez     = 1'b0;
        syscall  = 1'b0;
        known    = 1'b1;

        case (funct)
            decodePkg::FN_SLLV: begin
                aluOp    = decodePkg::ALU_PASS;    // shifter handles sllv
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_ADD: begin
                aluOp    = decodePkg::ALU_ADD;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_ADDU: begin
                aluOp    = decodePkg::ALU_ADD;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_SUB: begin
                aluOp    = decodePkg::ALU_SUB;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_AND: begin
                aluOp    = decodePkg::ALU_AND;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_OR: begin
                aluOp    = decodePkg::ALU_OR;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_NOR: begin
                aluOp    = decodePkg::ALU_NOR;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_SLT: begin
                aluOp    = decodePkg::ALU_SLT;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_SLTU: begin
                aluOp    = decodePkg::ALU_SLTU;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_SLL: begin
                aluOp    = decodePkg::ALU_SLL;
                extOp    = decodePkg::EXT_SHAMT;    // B comes from shamt
                aluSrc   = 1'b1;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_SRA: begin
                aluOp    = decodePkg::ALU_SRA;
                extOp    = decodePkg::EXT_SHAMT;
                aluSrc   = 1'b1;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_SRL: begin
                aluOp    = decodePkg::ALU_SRL;
                extOp    = decodePkg::EXT_SHAMT;
                aluSrc   = 1'b1;
                regDst   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::FN_JR:      jr      = 1'b1;
            decodePkg::FN_SYSCALL: syscall = 1'b1;
            default:               known   = 1'b0;    // all controls stay idle
        endcase
    end

endmodule

/* decoder/primaryDecode.sv */
`timescale 1ns/10ps

module primaryDecode (
    input  decodePkg::opcodeT opcode,
    output decodePkg::aluOpT  aluOp,
    output decodePkg::extOpT  extOp,
    output logic              aluSrc,
    output logic              regDst,
    output logic              regWrite,
    output logic              memWrite,
    output logic              memToReg,
    output logic              loadByte,
    output logic              lui,
    output logic              jr,
    output logic              jal,
    output logic              j,
    output logic              beq,
    output logic              bne,
    output logic              blez,
    output logic              syscall,
    output logic              known
);

    always_comb begin
        aluOp    = decodePkg::ALU_PASS;
        extOp    = decodePkg::EXT_SIGN;
        aluSrc   = 1'b0;
        regDst   = 1'b0;
        regWrite = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        loadByte = 1'b0;
        lui      = 1'b0;
        jr       = 1'b0;
        jal      = 1'b0;
        j        = 1'b0;
        beq      = 1'b0;
        bne      = 1'b0;
        blez     = 1'b0;
        syscall  = 1'b0;
        known    = 1'b1;

        case (opcode)
            ////////////////////////////////////////////////////////////////////
            // immediate ALU
            ////////////////////////////////////////////////////////////////////
            decodePkg::OP_ADDI: begin
                aluOp    = decodePkg::ALU_ADD;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::OP_ADDIU: begin
                aluOp    = decodePkg::ALU_ADD;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::OP_ANDI: begin
                aluOp    = decodePkg::ALU_AND;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::OP_ORI: begin
                aluOp    = decodePkg::ALU_OR;
                extOp    = decodePkg::EXT_ZERO;    // logical immediate
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::OP_SLTI: begin
                aluOp    = decodePkg::ALU_SLT;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
            end
            decodePkg::OP_LUI: begin
                aluOp    = decodePkg::ALU_SLT;    // result path bypasses ALU
                lui      = 1'b1;
                regWrite = 1'b1;
            end

            ////////////////////////////////////////////////////////////////////
            // memory
            ////////////////////////////////////////////////////////////////////
            decodePkg::OP_LB: begin
                aluOp    = decodePkg::ALU_ADD;    // base + offset
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memToReg = 1'b1;
                loadByte = 1'b1;
            end
            decodePkg::OP_LW: begin
                aluOp    = decodePkg::ALU_ADD;
                aluSrc   = 1'b1;
                regWrite = 1'b1;
                memToReg = 1'b1;
            end
            decodePkg::OP_SW: begin
                aluOp    = decodePkg::ALU_ADD;
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end

            ////////////////////////////////////////////////////////////////////
            // branches and jumps
            ////////////////////////////////////////////////////////////////////
            decodePkg::OP_BLEZ: begin
                aluOp = decodePkg::ALU_SLT;
                blez  = 1'b1;
            end
            decodePkg::OP_BEQ: beq = 1'b1;
            decodePkg::OP_BNE: bne = 1'b1;
            decodePkg::OP_J:   j   = 1'b1;
            decodePkg::OP_JAL: begin
                jal      = 1'b1;
                regWrite = 1'b1;    // link register write
            end
            default: known = 1'b0;    // includes OP_SPECIAL
        endcase
    end

endmodule

/* decoder/operandDeps.sv */
`timescale 1ns/10ps

module operandDeps (
    input  decodePkg::instrT   instr,
    output decodePkg::regAddrT destReg,
    output logic               dependsA,
    output logic               dependsB
);

    decodePkg::opcodeT  opcode;
    decodePkg::functT   funct;
    decodePkg::regAddrT rt;
    decodePkg::regAddrT rd;

    assign opcode = instr[decodePkg::OPCODE_LSB +: decodePkg::OPCODE_W];
    assign funct  = instr[decodePkg::FUNCT_W-1:0];
    assign rt     = instr[decodePkg::RT_LSB +: decodePkg::REG_ADDR_W];
    assign rd     = instr[decodePkg::RD_LSB +: decodePkg::REG_ADDR_W];

    always_comb begin
        destReg  = '0;    // nothing written
        dependsA = 1'b0;
        dependsB = 1'b0;

        if (opcode == decodePkg::OP_SPECIAL) begin
            case (funct)
                decodePkg::FN_SLLV, decodePkg::FN_ADD, decodePkg::FN_ADDU,
                decodePkg::FN_SUB, decodePkg::FN_AND, decodePkg::FN_OR,
                decodePkg::FN_NOR, decodePkg::FN_SLT, decodePkg::FN_SLTU: begin
                    destReg  = rd;
                    dependsA = 1'b1;
                    dependsB = 1'b1;
                end
                decodePkg::FN_SLL, decodePkg::FN_SRA, decodePkg::FN_SRL: begin
                    destReg  = rd;
                    dependsA = 1'b1;    // B is the shift amount
                end
                decodePkg::FN_JR: dependsA = 1'b1;
                decodePkg::FN_SYSCALL: begin
                    dependsA = 1'b1;    // service number and argument
                    dependsB = 1'b1;
                end
                default: ;
            endcase
        end else begin
            case (opcode)
                decodePkg::OP_ADDI, decodePkg::OP_ADDIU, decodePkg::OP_ANDI,
                decodePkg::OP_ORI, decodePkg::OP_SLTI, decodePkg::OP_LB,
                decodePkg::OP_LW: begin
                    destReg  = rt;
                    dependsA = 1'b1;
                end
                decodePkg::OP_LUI: destReg = rt;
                decodePkg::OP_JAL: destReg = decodePkg::LINK_REG;
                decodePkg::OP_BEQ, decodePkg::OP_BNE, decodePkg::OP_SW: begin
                    dependsA = 1'b1;
                    dependsB = 1'b1;    // compare operand or store data
                end
                decodePkg::OP_BLEZ: dependsA = 1'b1;
                default: ;    // j and unknown opcodes
            endcase
        end
    end

endmodule

/* decoder/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
    input  decodePkg::instrT   instr,
    output decodePkg::aluOpT   aluOp,
    output decodePkg::extOpT   extOp,
    output logic               aluSrc,
    output logic               regDst,
    output logic               regWrite,
    output logic               memWrite,
    output logic               memToReg,
    output logic               loadByte,
    output logic               lui,
    output logic               jr,
    output logic               jal,
    output logic               j,
    output logic               beq,
    output logic               bne,
    output logic               blez,
    output logic               syscall,
    output decodePkg::regAddrT destReg,
    output logic               dependsA,
    output logic               dependsB
);

    decodePkg::opcodeT opcode;
    decodePkg::functT  funct;
    logic              isSpecial;

    decodePkg::aluOpT  specAluOp;
    decodePkg::extOpT  specExtOp;
    logic specAluSrc, specRegDst, specRegWrite, specMemWrite, specMemToReg, specLoadByte;
    logic specLui, specJr, specJal, specJ, specBeq, specBne, specBlez, specSyscall;

    decodePkg::aluOpT  primAluOp;
    decodePkg::extOpT  primExtOp;
    logic primAluSrc, primRegDst, primRegWrite, primMemWrite, primMemToReg, primLoadByte;
    logic primLui, primJr, primJal, primJ, primBeq, primBne, primBlez, primSyscall;

    assign opcode    = instr[decodePkg::OPCODE_LSB +: decodePkg::OPCODE_W];
    assign funct     = instr[decodePkg::FUNCT_W-1:0];
    assign isSpecial = (opcode == decodePkg::OP_SPECIAL);

    ////////////////////////////////////////////////////////////////////////////
    // table decoders and operand dependencies
    ////////////////////////////////////////////////////////////////////////////

    specialDecode specialDec_i (
        .funct(funct), .aluOp(specAluOp), .extOp(specExtOp),
        .aluSrc(specAluSrc), .regDst(specRegDst), .regWrite(specRegWrite),
        .memWrite(specMemWrite), .memToReg(specMemToReg), .loadByte(specLoadByte),
        .lui(specLui), .jr(specJr), .jal(specJal), .j(specJ),
        .beq(specBeq), .bne(specBne), .blez(specBlez), .syscall(specSyscall),
        .known()
    );

    primaryDecode primaryDec_i (
        .opcode(opcode), .aluOp(primAluOp), .extOp(primExtOp),
        .aluSrc(primAluSrc), .regDst(primRegDst), .regWrite(primRegWrite),
        .memWrite(primMemWrite), .memToReg(primMemToReg), .loadByte(primLoadByte),
        .lui(primLui), .jr(primJr), .jal(primJal), .j(primJ),
        .beq(primBeq), .bne(primBne), .blez(primBlez), .syscall(primSyscall),
        .known()
    );

    operandDeps operandDeps_i (
        .instr(instr), .destReg(destReg), .dependsA(dependsA), .dependsB(dependsB)
    );

    assign aluOp    = isSpecial ? specAluOp    : primAluOp;
    assign extOp    = isSpecial ? specExtOp    : primExtOp;
    assign aluSrc   = isSpecial ? specAluSrc   : primAluSrc;
    assign regDst   = isSpecial ? specRegDst   : primRegDst;
    assign regWrite = isSpecial ? specRegWrite : primRegWrite;
    assign memWrite = isSpecial ? specMemWrite : primMemWrite;
    assign memToReg = isSpecial ? specMemToReg : primMemToReg;
    assign loadByte = isSpecial ? specLoadByte : primLoadByte;
    assign lui      = isSpecial ? specLui      : primLui;
    assign jr       = isSpecial ? specJr       : primJr;
    assign jal      = isSpecial ? specJal      : primJal;
    assign j        = isSpecial ? specJ        : primJ;
    assign beq      = isSpecial ? specBeq      : primBeq;
    assign bne      = isSpecial ? specBne      : primBne;
    assign blez     = isSpecial ? specBlez     : primBlez;
    assign syscall  = isSpecial ? specSyscall  : primSyscall;

endmodule

/* verification/instrDecoderTb.sv */
`timescale 1ns/10ps

module instrDecoderTb;

    localparam int CTL_W = 27;
    localparam PATTERN_FILE = "verification/decode_patterns.txt";

    logic               clk;
    logic               rst;
    decodePkg::instrT   instr;
    decodePkg::aluOpT   aluOp;
    decodePkg::extOpT   extOp;
    logic               aluSrc;
    logic               regDst;
    logic               regWrite;
    logic               memWrite;
    logic               memToReg;
    logic               loadByte;
    logic               lui;
    logic               jr;
    logic               jal;
    logic               j;
    logic               beq;
    logic               bne;
    logic               blez;
    logic               syscall;
    decodePkg::regAddrT destReg;
    logic               dependsA;
    logic               dependsB;

    decodePkg::instrT   wordQ[$];
    logic [CTL_W-1:0]   ctlQ[$];
    int                 errorCount;
    int                 checkCount;
    int                 cycleCount;
    int                 cycleLimit;

    instrDecoder dut_i (
        .instr(instr), .aluOp(aluOp), .extOp(extOp),
        .aluSrc(aluSrc), .regDst(regDst), .regWrite(regWrite),
        .memWrite(memWrite), .memToReg(memToReg), .loadByte(loadByte),
        .lui(lui), .jr(jr), .jal(jal), .j(j),
        .beq(beq), .bne(bne), .blez(blez), .syscall(syscall),
        .destReg(destReg), .dependsA(dependsA), .dependsB(dependsB)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;    // 20 ns period
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: run still going after %0d cycles", cycleLimit);
            $display("test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic loadPatterns();
        int               fd;
        int               fields;
        logic [8*256-1:0] lineBuf;
        logic [31:0]      wordVal;
        logic [31:0]      ctlVal;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("could not open the pattern file %s", PATTERN_FILE);
            errorCount++;
            return;
        end
        while (!$feof(fd)) begin
            lineBuf = '0;
            if ($fgets(lineBuf, fd) != 0) begin
                fields = $sscanf(lineBuf, "%h %h", wordVal, ctlVal);    // comment lines give 0
                if (fields == 2) begin
                    wordQ.push_back(wordVal);
                    ctlQ.push_back(ctlVal[CTL_W-1:0]);
                end
            end
        end
        $fclose(fd);
        if (wordQ.size() == 0) begin
            $display("the pattern file holds no instructions");
            errorCount++;
        end
    endtask

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        checkCount++;
        assert (actVal === expVal) else begin
            $display("FAIL %s instr=%h expected=%0h actual=%0h", name, instr, expVal, actVal);
            errorCount++;
        end
    endtask

    task automatic checkOutputs(input logic [CTL_W-1:0] expCtl);
        int flagCount;
        flagCount = $countones({jr, jal, j, beq, bne, blez, syscall});
        checkField("aluOp",    expCtl[26:23], aluOp);
        checkField("extOp",    expCtl[22:21], extOp);
        checkField("aluSrc",   expCtl[20],    aluSrc);
        checkField("regDst",   expCtl[19],    regDst);
        checkField("regWrite", expCtl[18],    regWrite);
        checkField("memWrite", expCtl[17],    memWrite);
        checkField("memToReg", expCtl[16],    memToReg);
        checkField("loadByte", expCtl[15],    loadByte);
        checkField("lui",      expCtl[14],    lui);
        checkField("jr",       expCtl[13],    jr);
        checkField("jal",      expCtl[12],    jal);
        checkField("j",        expCtl[11],    j);
        checkField("beq",      expCtl[10],    beq);
        checkField("bne",      expCtl[9],     bne);
        checkField("blez",     expCtl[8],     blez);
        checkField("syscall",  expCtl[7],     syscall);
        checkField("destReg",  expCtl[6:2],   destReg);
        checkField("dependsA", expCtl[1],     dependsA);
        checkField("dependsB", expCtl[0],     dependsB);

        // control transfer must be one-hot or idle
        assert (flagCount <= 1) else begin
            $display("instr %h raised more than one control-transfer flag", instr);
            errorCount++;
        end
        assert (!(flagCount != 0 && memWrite)) else begin
            $display("instr %h is a branch or jump but also writes memory", instr);
            errorCount++;
        end
    endtask

    // fresh rs, rt and rd with opcode and funct kept
    function automatic decodePkg::instrT scrambleRegFields(decodePkg::instrT word);
        decodePkg::instrT mixed;
        logic [31:0]      randomBits;
        randomBits   = $urandom;
        mixed        = word;
        mixed[25:11] = randomBits[14:0];
        return mixed;
    endfunction

    function automatic decodePkg::regAddrT expectedDest(logic [CTL_W-1:0] ctl,
                                                        decodePkg::instrT word);
        if (ctl[19])
            return word[decodePkg::RD_LSB +: decodePkg::REG_ADDR_W];    // register format
        else if (ctl[12])
            return 5'd31;    // link register
        else if (ctl[18])
            return word[decodePkg::RT_LSB +: decodePkg::REG_ADDR_W];
        else
            return '0;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        decodePkg::instrT replayWord;
        logic [CTL_W-1:0] replayCtl;
        logic [31:0]      seedVal;
        rst        = 1'b1;
        instr      = '0;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        cycleLimit = 20;
        seedVal    = $urandom(32'he451);

        loadPatterns();
        cycleLimit = 2 * wordQ.size() + 20;    // two cycles per pattern

        repeat (2) @(posedge clk);
        rst <= 1'b0;
        wait (rst == 1'b0);

        foreach (wordQ[i]) begin
            @(posedge clk);
            instr <= wordQ[i];
            @(negedge clk);
            checkOutputs(ctlQ[i]);

            replayWord      = scrambleRegFields(wordQ[i]);
            replayCtl       = ctlQ[i];
            replayCtl[6:2]  = expectedDest(ctlQ[i], replayWord);
            @(posedge clk);
            instr <= replayWord;
            @(negedge clk);
            checkOutputs(replayCtl);
        end

        $display("decoder checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* files.f */
common/decodePkg.sv
decoder/specialDecode.sv
decoder/primaryDecode.sv
decoder/operandDeps.sv
decoder/instrDecoder.sv
verification/instrDecoderTb.sv

/* verification/decode_patterns.txt */
# instr ctl  ctl = aluOp[26:23] extOp[22:21] aluSrc regDst regWrite memWrite memToReg
# loadByte lui jr jal j beq bne blez syscall[7] destReg[6:2] dependsA dependsB[0]
00221804 068C000F  sllv
00221820 028C000F  add
00221821 028C000F  addu
00221822 030C000F  sub
00221824 038C000F  and
00221825 040C000F  or
00221827 050C000F  nor
0022182A 058C000F  slt
0022182B 060C000F  sltu
00221900 005C000E  sll
00221903 00DC000E  sra
00221902 015C000E  srl
00000000 005C0002  nop
00200008 06802002  jr
0000000C 06800083  syscall
00221801 06800000  unknown funct
0022180D 06800000  unknown funct
00221818 06800000  unknown funct
0022183F 06800000  unknown funct
20221234 0294000A  addi
24221234 0294000A  addiu
28221234 0594000A  slti
30221234 0394000A  andi
34221234 0434000A  ori
3C021234 05844008  lui
80221234 0295800A  lb
8C221234 0295000A  lw
AC221234 02920003  sw
10220010 06800403  beq
14220010 06800203  bne
18200010 05800102  blez
08100040 06800800  j
0C100040 0684107C  jal
04221234 06800000  unknown opcode
1C220010 06800000  unknown opcode
90221234 06800000  unknown opcode
FC221234 06800000  unknown opcode
